// File: hdl/secv_pkg.sv
// Word-only RV32I subset; any opcode or funct pattern not listed here is decoded as illegal
package secv_pkg;

    // Data, instruction and register index widths
    localparam int XLEN    = 32;
    localparam int ILEN    = 32;
    localparam int REG_ADR = 5;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [ILEN-1:0]    inst_t;
    typedef logic [REG_ADR-1:0] reg_adr_t;

    // Major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    // ALU funct3 codes, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Word access and JALR
    localparam logic [2:0] F3_WORD = 3'b010;
    localparam logic [2:0] F3_JALR = 3'b000;

    // funct7: base ops, and SUB / SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS2
    } alu_op_t;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO} src1_sel_t;
    typedef enum logic {SRC2_RS2, SRC2_IMM} src2_sel_t;
    typedef enum logic [1:0] {RD_NONE, RD_ALU, RD_LOAD, RD_NXTPC} rd_sel_t;
    typedef enum logic [1:0] {PC_NXT, PC_ALU, PC_BRANCH} pc_sel_t;
    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_t;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_EXECUTE, ST_MEM, ST_WB, ST_HALT
    } state_t;

endpackage

// File: hdl/secv_decode.sv
// Purely combinational; only the kept RV32I subset decodes, everything else raises illegal_o
module secv_decode (
    input  secv_pkg::inst_t     ir_i,
    output secv_pkg::reg_adr_t  rs1_adr_o,
    output secv_pkg::reg_adr_t  rs2_adr_o,
    output secv_pkg::reg_adr_t  rd_adr_o,
    output secv_pkg::word_t     imm_o,
    output secv_pkg::alu_op_t   alu_op_o,
    output secv_pkg::src1_sel_t src1_sel_o,
    output secv_pkg::src2_sel_t src2_sel_o,
    output secv_pkg::rd_sel_t   rd_sel_o,
    output secv_pkg::pc_sel_t   pc_sel_o,
    output secv_pkg::mem_op_t   mem_op_o,
    output logic                illegal_o
);
    secv_pkg::opcode_t opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    secv_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    secv_pkg::alu_op_t alu_dec;
    logic              alu_err;

    assign opcode    = secv_pkg::opcode_t'(ir_i[6:0]);
    assign funct3    = ir_i[14:12];
    assign funct7    = ir_i[31:25];
    assign rd_adr_o  = ir_i[11:7];
    assign rs1_adr_o = ir_i[19:15];
    assign rs2_adr_o = ir_i[24:20];

    // Sign-extended immediate formats
    assign imm_i = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_s = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_b = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    assign imm_u = {ir_i[31:12], 12'b0};
    assign imm_j = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

    // ALU op from funct3/funct7; OP_IMM ignores funct7 except on shifts
    always_comb begin
        alu_dec = secv_pkg::ALU_ADD;
        alu_err = (opcode == secv_pkg::OP) && (funct7 != secv_pkg::F7_BASE);
        case (funct3)
            secv_pkg::F3_ADD: begin
                if (opcode == secv_pkg::OP && funct7 == secv_pkg::F7_ALT) begin
                    alu_dec = secv_pkg::ALU_SUB;
                    alu_err = 1'b0;
                end
            end
            secv_pkg::F3_SLL: begin
                alu_dec = secv_pkg::ALU_SLL;
                alu_err = funct7 != secv_pkg::F7_BASE;
            end
            secv_pkg::F3_SR: begin
                alu_dec = (funct7 == secv_pkg::F7_ALT) ? secv_pkg::ALU_SRA : secv_pkg::ALU_SRL;
                alu_err = funct7 != secv_pkg::F7_BASE && funct7 != secv_pkg::F7_ALT;
            end
            secv_pkg::F3_SLT:  alu_dec = secv_pkg::ALU_SLT;
            secv_pkg::F3_SLTU: alu_dec = secv_pkg::ALU_SLTU;
            secv_pkg::F3_XOR:  alu_dec = secv_pkg::ALU_XOR;
            secv_pkg::F3_OR:   alu_dec = secv_pkg::ALU_OR;
            default:           alu_dec = secv_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        // Defaults fit the I-type ALU case
        alu_op_o   = secv_pkg::ALU_ADD;
        src1_sel_o = secv_pkg::SRC1_RS1;
        src2_sel_o = secv_pkg::SRC2_IMM;
        rd_sel_o   = secv_pkg::RD_NONE;
        pc_sel_o   = secv_pkg::PC_NXT;
        mem_op_o   = secv_pkg::MEM_NONE;
        imm_o      = imm_i;
        illegal_o  = 1'b0;
        case (opcode)
            secv_pkg::OP, secv_pkg::OP_IMM: begin
                alu_op_o  = alu_dec;
                rd_sel_o  = secv_pkg::RD_ALU;
                illegal_o = alu_err;
                if (opcode == secv_pkg::OP)
                    src2_sel_o = secv_pkg::SRC2_RS2;
            end
            secv_pkg::LUI: begin
                alu_op_o = secv_pkg::ALU_PASS2;
                imm_o    = imm_u;
                rd_sel_o = secv_pkg::RD_ALU;
            end
            secv_pkg::AUIPC: begin
                src1_sel_o = secv_pkg::SRC1_PC;
                imm_o      = imm_u;
                rd_sel_o   = secv_pkg::RD_ALU;
            end
            // Link value is pc + 4, target from the ALU
            secv_pkg::JAL: begin
                src1_sel_o = secv_pkg::SRC1_PC;
                imm_o      = imm_j;
                rd_sel_o   = secv_pkg::RD_NXTPC;
                pc_sel_o   = secv_pkg::PC_ALU;
            end
            secv_pkg::JALR: begin
                rd_sel_o  = secv_pkg::RD_NXTPC;
                pc_sel_o  = secv_pkg::PC_ALU;
                illegal_o = funct3 != secv_pkg::F3_JALR;
            end
            secv_pkg::BRANCH: begin
                src1_sel_o = secv_pkg::SRC1_PC;
                imm_o      = imm_b;
                pc_sel_o   = secv_pkg::PC_BRANCH;
                illegal_o  = !(funct3 inside {secv_pkg::F3_BEQ, secv_pkg::F3_BNE,
                    secv_pkg::F3_BLT, secv_pkg::F3_BGE, secv_pkg::F3_BLTU, secv_pkg::F3_BGEU});
            end
            secv_pkg::LOAD: begin
                rd_sel_o  = secv_pkg::RD_LOAD;
                mem_op_o  = secv_pkg::MEM_LOAD;
                illegal_o = funct3 != secv_pkg::F3_WORD;
            end
            secv_pkg::STORE: begin
                imm_o     = imm_s;
                mem_op_o  = secv_pkg::MEM_STORE;
                illegal_o = funct3 != secv_pkg::F3_WORD;
            end
            default: illegal_o = 1'b1;
        endcase
        // No side effects from an unknown instruction
        if (illegal_o) begin
            rd_sel_o = secv_pkg::RD_NONE;
            mem_op_o = secv_pkg::MEM_NONE;
        end
    end
endmodule

// File: hdl/secv_execute.sv
// Combinational ALU and branch compare; funct3_i is only meaningful for branch instructions
module secv_execute (
    input  secv_pkg::word_t     rs1_dat_i,
    input  secv_pkg::word_t     rs2_dat_i,
    input  secv_pkg::word_t     pc_i,
    input  secv_pkg::word_t     imm_i,
    input  secv_pkg::alu_op_t   alu_op_i,
    input  secv_pkg::src1_sel_t src1_sel_i,
    input  secv_pkg::src2_sel_t src2_sel_i,
    input  logic [2:0]          funct3_i,
    output secv_pkg::word_t     alu_res_o,
    output logic                take_o
);
    secv_pkg::word_t src1, src2;
    logic [4:0]      shamt;

    // Operand muxes
    always_comb begin
        case (src1_sel_i)
            secv_pkg::SRC1_PC:  src1 = pc_i;
            secv_pkg::SRC1_RS1: src1 = rs1_dat_i;
            default:            src1 = '0;
        endcase
    end

    assign src2  = (src2_sel_i == secv_pkg::SRC2_RS2) ? rs2_dat_i : imm_i;
    assign shamt = src2[4:0];

    always_comb begin
        case (alu_op_i)
            secv_pkg::ALU_SUB:   alu_res_o = src1 - src2;
            secv_pkg::ALU_AND:   alu_res_o = src1 & src2;
            secv_pkg::ALU_OR:    alu_res_o = src1 | src2;
            secv_pkg::ALU_XOR:   alu_res_o = src1 ^ src2;
            secv_pkg::ALU_SLL:   alu_res_o = src1 << shamt;
            secv_pkg::ALU_SRL:   alu_res_o = src1 >> shamt;
            secv_pkg::ALU_SRA:   alu_res_o = $unsigned($signed(src1) >>> shamt);
            secv_pkg::ALU_SLT:
                alu_res_o = {{(secv_pkg::XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            secv_pkg::ALU_SLTU:
                alu_res_o = {{(secv_pkg::XLEN-1){1'b0}}, src1 < src2};
            secv_pkg::ALU_PASS2: alu_res_o = src2;
            // Also targets and memory addresses
            default:             alu_res_o = src1 + src2;
        endcase
    end

    // Branch decision always on the register operands
    always_comb begin
        case (funct3_i)
            secv_pkg::F3_BEQ:  take_o = rs1_dat_i == rs2_dat_i;
            secv_pkg::F3_BNE:  take_o = rs1_dat_i != rs2_dat_i;
            secv_pkg::F3_BLT:  take_o = $signed(rs1_dat_i) < $signed(rs2_dat_i);
            secv_pkg::F3_BGE:  take_o = $signed(rs1_dat_i) >= $signed(rs2_dat_i);
            secv_pkg::F3_BLTU: take_o = rs1_dat_i < rs2_dat_i;
            secv_pkg::F3_BGEU: take_o = rs1_dat_i >= rs2_dat_i;
            default:           take_o = 1'b0;
        endcase
    end
endmodule

// File: hdl/secv_writeback.sv
// Register file has no reset, only x0 reads as zero; pc resets to 0 and updates only on wb_en_i
module secv_writeback (
    input  logic                clk_i,
    input  logic                rst_i,
    input  secv_pkg::reg_adr_t  rs1_adr_i,
    input  secv_pkg::reg_adr_t  rs2_adr_i,
    input  secv_pkg::reg_adr_t  rd_adr_i,
    output secv_pkg::word_t     rs1_dat_o,
    output secv_pkg::word_t     rs2_dat_o,
    input  secv_pkg::word_t     alu_res_i,
    input  secv_pkg::word_t     load_dat_i,
    input  secv_pkg::rd_sel_t   rd_sel_i,
    input  secv_pkg::pc_sel_t   pc_sel_i,
    input  logic                take_i,
    input  logic                wb_en_i,
    output secv_pkg::word_t     pc_o
);
    secv_pkg::word_t regs [2**secv_pkg::REG_ADR];
    secv_pkg::word_t pc_inc, rd_dat, pc_nxt;

    assign rs1_dat_o = (rs1_adr_i == '0) ? '0 : regs[rs1_adr_i];
    assign rs2_dat_o = (rs2_adr_i == '0) ? '0 : regs[rs2_adr_i];
    assign pc_inc    = pc_o + 32'd4;

    // Result select
    always_comb begin
        case (rd_sel_i)
            secv_pkg::RD_LOAD:  rd_dat = load_dat_i;
            secv_pkg::RD_NXTPC: rd_dat = pc_inc;
            default:            rd_dat = alu_res_i;
        endcase
    end

    // Next pc; jump targets lose bit 0
    always_comb begin
        case (pc_sel_i)
            secv_pkg::PC_ALU:    pc_nxt = {alu_res_i[secv_pkg::XLEN-1:1], 1'b0};
            secv_pkg::PC_BRANCH: pc_nxt = take_i ? alu_res_i : pc_inc;
            default:             pc_nxt = pc_inc;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (wb_en_i && rd_sel_i != secv_pkg::RD_NONE && rd_adr_i != '0)
            regs[rd_adr_i] <= rd_dat;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            pc_o <= '0;
        else if (wb_en_i)
            pc_o <= pc_nxt;
    end
endmodule

// File: hdl/secv_control.sv
// Word accesses only, no select lines; a stalled ack stalls the core forever, halt holds until reset
module secv_control #(
    parameter int IADR_WIDTH = 10,
    parameter int DADR_WIDTH = 10
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Instruction bus
    output logic                  imem_cyc_o,
    output logic                  imem_stb_o,
    output logic [IADR_WIDTH-1:0] imem_adr_o,
    input  secv_pkg::inst_t       imem_dat_i,
    input  logic                  imem_ack_i,

    // Data bus
    output logic                  dmem_cyc_o,
    output logic                  dmem_stb_o,
    output logic                  dmem_we_o,
    output logic [DADR_WIDTH-1:0] dmem_adr_o,
    output secv_pkg::word_t       dmem_dat_o,
    input  secv_pkg::word_t       dmem_dat_i,
    input  logic                  dmem_ack_i,

    input  secv_pkg::word_t       pc_i,
    input  secv_pkg::word_t       alu_res_i,
    input  secv_pkg::word_t       rs2_dat_i,
    input  secv_pkg::mem_op_t     mem_op_i,
    input  logic                  illegal_i,
    output secv_pkg::inst_t       ir_o,
    output secv_pkg::word_t       load_dat_o,
    output logic                  wb_en_o,
    output logic                  halt_o
);
    secv_pkg::state_t state, state_nxt;

    // Byte addresses to word addresses
    assign imem_adr_o = pc_i[IADR_WIDTH+1:2];
    assign dmem_adr_o = alu_res_i[DADR_WIDTH+1:2];
    assign dmem_dat_o = rs2_dat_i;

    // Bus strobes follow the state only
    assign imem_cyc_o = state == secv_pkg::ST_FETCH;
    assign imem_stb_o = imem_cyc_o;
    assign dmem_cyc_o = state == secv_pkg::ST_MEM;
    assign dmem_stb_o = dmem_cyc_o;
    assign dmem_we_o  = dmem_cyc_o && mem_op_i == secv_pkg::MEM_STORE;
    assign wb_en_o    = state == secv_pkg::ST_WB;
    assign halt_o     = state == secv_pkg::ST_HALT;

    always_comb begin
        state_nxt = state;
        case (state)
            secv_pkg::ST_IDLE: state_nxt = secv_pkg::ST_FETCH;
            // Wait here as long as the slave holds off ack
            secv_pkg::ST_FETCH: begin
                if (imem_ack_i)
                    state_nxt = secv_pkg::ST_DECODE;
            end
            secv_pkg::ST_DECODE:
                state_nxt = illegal_i ? secv_pkg::ST_HALT : secv_pkg::ST_EXECUTE;
            // Skip the data bus for non-memory ops
            secv_pkg::ST_EXECUTE:
                state_nxt = (mem_op_i == secv_pkg::MEM_NONE) ? secv_pkg::ST_WB
                                                             : secv_pkg::ST_MEM;
            secv_pkg::ST_MEM: begin
                if (dmem_ack_i)
                    state_nxt = secv_pkg::ST_WB;
            end
            secv_pkg::ST_WB:   state_nxt = secv_pkg::ST_FETCH;
            default:           state_nxt = secv_pkg::ST_HALT;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            state <= secv_pkg::ST_IDLE;
        else
            state <= state_nxt;
    end

    // Instruction and load data registers, sampled in the ack cycle
    always_ff @(posedge clk_i) begin
        if (state == secv_pkg::ST_FETCH && imem_ack_i)
            ir_o <= imem_dat_i;
        if (state == secv_pkg::ST_MEM && dmem_ack_i && mem_op_i == secv_pkg::MEM_LOAD)
            load_dat_o <= dmem_dat_i;
    end
endmodule

// File: hdl/secv_top.sv
// Multi-cycle core, one instruction at a time; bus addresses are word addresses (byte address >> 2)
module secv_top #(
    parameter int IADR_WIDTH = 10,
    parameter int DADR_WIDTH = 10
) (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Instruction bus
    output logic                  imem_cyc_o,
    output logic                  imem_stb_o,
    output logic [IADR_WIDTH-1:0] imem_adr_o,
    input  secv_pkg::inst_t       imem_dat_i,
    input  logic                  imem_ack_i,

    // Data bus
    output logic                  dmem_cyc_o,
    output logic                  dmem_stb_o,
    output logic                  dmem_we_o,
    output logic [DADR_WIDTH-1:0] dmem_adr_o,
    output secv_pkg::word_t       dmem_dat_o,
    input  secv_pkg::word_t       dmem_dat_i,
    input  logic                  dmem_ack_i,

    output logic                  halt_o
);
    secv_pkg::inst_t       ir;
    secv_pkg::reg_adr_t    rs1_adr, rs2_adr, rd_adr;
    secv_pkg::word_t       imm, rs1_dat, rs2_dat, pc, alu_res, load_dat;
    secv_pkg::alu_op_t     alu_op;
    secv_pkg::src1_sel_t   src1_sel;
    secv_pkg::src2_sel_t   src2_sel;
    secv_pkg::rd_sel_t     rd_sel;
    secv_pkg::pc_sel_t     pc_sel;
    secv_pkg::mem_op_t     mem_op;
    logic                  illegal, take, wb_en;

    secv_control #(
        .IADR_WIDTH(IADR_WIDTH),
        .DADR_WIDTH(DADR_WIDTH)
    ) i_control (
        .clk_i, .rst_i,
        .imem_cyc_o, .imem_stb_o, .imem_adr_o, .imem_dat_i, .imem_ack_i,
        .dmem_cyc_o, .dmem_stb_o, .dmem_we_o, .dmem_adr_o, .dmem_dat_o,
        .dmem_dat_i, .dmem_ack_i,
        .pc_i       (pc),
        .alu_res_i  (alu_res),
        .rs2_dat_i  (rs2_dat),
        .mem_op_i   (mem_op),
        .illegal_i  (illegal),
        .ir_o       (ir),
        .load_dat_o (load_dat),
        .wb_en_o    (wb_en),
        .halt_o
    );

    secv_decode i_decode (
        .ir_i       (ir),
        .rs1_adr_o  (rs1_adr),
        .rs2_adr_o  (rs2_adr),
        .rd_adr_o   (rd_adr),
        .imm_o      (imm),
        .alu_op_o   (alu_op),
        .src1_sel_o (src1_sel),
        .src2_sel_o (src2_sel),
        .rd_sel_o   (rd_sel),
        .pc_sel_o   (pc_sel),
        .mem_op_o   (mem_op),
        .illegal_o  (illegal)
    );

    // Branch condition comes straight from the funct3 field
    secv_execute i_execute (
        .rs1_dat_i (rs1_dat),
        .rs2_dat_i (rs2_dat),
        .pc_i      (pc),
        .imm_i     (imm),
        .alu_op_i  (alu_op),
        .src1_sel_i(src1_sel),
        .src2_sel_i(src2_sel),
        .funct3_i  (ir[14:12]),
        .alu_res_o (alu_res),
        .take_o    (take)
    );

    secv_writeback i_writeback (
        .clk_i, .rst_i,
        .rs1_adr_i (rs1_adr),
        .rs2_adr_i (rs2_adr),
        .rd_adr_i  (rd_adr),
        .rs1_dat_o (rs1_dat),
        .rs2_dat_o (rs2_dat),
        .alu_res_i (alu_res),
        .load_dat_i(load_dat),
        .rd_sel_i  (rd_sel),
        .pc_sel_i  (pc_sel),
        .take_i    (take),
        .wb_en_i   (wb_en),
        .pc_o      (pc)
    );
endmodule

// File: dv/secv_bus_asserts.sv
// Bound into secv_control; checks Wishbone classic handshakes and that halt keeps both buses idle
module secv_bus_asserts #(
    parameter int IADR_WIDTH = 10,
    parameter int DADR_WIDTH = 10
) (
    input logic                  clk_i,
    input logic                  rst_i,
    input logic                  imem_cyc_o,
    input logic                  imem_stb_o,
    input logic [IADR_WIDTH-1:0] imem_adr_o,
    input logic                  imem_ack_i,
    input logic                  dmem_cyc_o,
    input logic                  dmem_stb_o,
    input logic                  dmem_we_o,
    input logic [DADR_WIDTH-1:0] dmem_adr_o,
    input secv_pkg::word_t       dmem_dat_o,
    input logic                  dmem_ack_i,
    input secv_pkg::state_t      state
);
    // Strobe only inside a cycle
    a_imem_stb: assert property (@(posedge clk_i) disable iff (rst_i) imem_stb_o |-> imem_cyc_o)
        else $error("imem stb without cyc");
    a_dmem_stb: assert property (@(posedge clk_i) disable iff (rst_i) dmem_stb_o |-> dmem_cyc_o)
        else $error("dmem stb without cyc");

    // Request held steady until ack
    a_imem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        imem_cyc_o && !imem_ack_i |=> imem_cyc_o && $stable(imem_adr_o))
        else $error("imem request changed before ack");
    a_dmem_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        dmem_cyc_o && !dmem_ack_i |=> dmem_cyc_o && $stable(dmem_adr_o)
            && $stable(dmem_we_o) && $stable(dmem_dat_o))
        else $error("dmem request changed before ack");

    a_reset_idle: assert property (@(posedge clk_i)
        rst_i |=> !imem_cyc_o && !imem_stb_o && !dmem_cyc_o && !dmem_stb_o && !dmem_we_o)
        else $error("bus active right after reset");

    // Halt is sticky until reset, with no bus traffic
    a_halt_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        state == secv_pkg::ST_HALT
            |=> state == secv_pkg::ST_HALT && !imem_cyc_o && !dmem_cyc_o)
        else $error("core left halt or started a bus cycle while halted");
endmodule

bind secv_control secv_bus_asserts #(
    .IADR_WIDTH(IADR_WIDTH),
    .DADR_WIDTH(DADR_WIDTH)
) i_bus_asserts (
    .clk_i(clk_i), .rst_i(rst_i),
    .imem_cyc_o(imem_cyc_o), .imem_stb_o(imem_stb_o), .imem_adr_o(imem_adr_o),
    .imem_ack_i(imem_ack_i),
    .dmem_cyc_o(dmem_cyc_o), .dmem_stb_o(dmem_stb_o), .dmem_we_o(dmem_we_o),
    .dmem_adr_o(dmem_adr_o), .dmem_dat_o(dmem_dat_o), .dmem_ack_i(dmem_ack_i),
    .state(state)
);

// File: dv/secv_tb.sv
// Program, data and expected stores come from dv/secv_testdata.txt; ack delay is 0 to 3 cycles
module secv_tb;
    localparam int IADR_WIDTH      = 10;
    localparam int DADR_WIDTH      = 10;
    localparam int CYCLES_PER_WORD = 200;
    localparam int HALT_IDLE       = 20;

    logic                  clk_i;
    logic                  rst_i;
    logic                  imem_cyc, imem_stb, imem_ack;
    logic [IADR_WIDTH-1:0] imem_adr;
    secv_pkg::inst_t       imem_dat;
    logic                  dmem_cyc, dmem_stb, dmem_we, dmem_ack;
    logic [DADR_WIDTH-1:0] dmem_adr;
    secv_pkg::word_t       dmem_wdat, dmem_rdat;
    logic                  halt;

    // Memory images
    secv_pkg::inst_t       imem [2**IADR_WIDTH];
    secv_pkg::word_t       dmem [2**DADR_WIDTH];

    // Expected stores, in program order
    logic [DADR_WIDTH-1:0] exp_adr_q [$];
    secv_pkg::word_t       exp_dat_q [$];
    int                    prog_words = 0;
    int                    store_cnt  = 0;
    logic                  first_fetch;

    // Per-bus wait state generators
    logic [31:0]           imem_rnd, dmem_rnd;
    logic                  imem_pend, dmem_pend;
    logic [1:0]            imem_wait, dmem_wait;
    logic [DADR_WIDTH-1:0] got_adr;

    secv_top #(
        .IADR_WIDTH(IADR_WIDTH),
        .DADR_WIDTH(DADR_WIDTH)
    ) i_dut (
        .clk_i, .rst_i,
        .imem_cyc_o(imem_cyc), .imem_stb_o(imem_stb), .imem_adr_o(imem_adr),
        .imem_dat_i(imem_dat), .imem_ack_i(imem_ack),
        .dmem_cyc_o(dmem_cyc), .dmem_stb_o(dmem_stb), .dmem_we_o(dmem_we),
        .dmem_adr_o(dmem_adr), .dmem_dat_o(dmem_wdat),
        .dmem_dat_i(dmem_rdat), .dmem_ack_i(dmem_ack),
        .halt_o(halt)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input secv_pkg::word_t got,
                              input secv_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_adr(input string name, input logic [DADR_WIDTH-1:0] got,
                             input logic [DADR_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // P = program word, D = data word, S = expected store
    task automatic load_testdata();
        int          fd;
        int          cnt;
        string       line;
        byte         kind;
        logic [31:0] a, d;
        fd = $fopen("dv/secv_testdata.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test data file");
            abort_run();
        end
        while (!$feof(fd)) begin
            cnt = $fgets(line, fd);
            if (cnt == 0 || line.len() < 2 || line.getc(0) == "#")
                continue;
            cnt = $sscanf(line, "%c %h %h", kind, a, d);
            if (cnt != 3)
                continue;
            case (kind)
                "P": begin
                    imem[a[IADR_WIDTH-1:0]] = d;
                    prog_words++;
                end
                "D": dmem[a[DADR_WIDTH-1:0]] = d;
                "S": begin
                    exp_adr_q.push_back(a[DADR_WIDTH-1:0]);
                    exp_dat_q.push_back(d);
                end
                default: ;
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Instruction memory slave
    always @(negedge clk_i) begin
        if (rst_i || imem_ack) begin
            imem_ack  = 1'b0;
            imem_pend = 1'b0;
        end else if (imem_cyc && imem_stb) begin
            if (!imem_pend) begin
                imem_pend = 1'b1;
                imem_rnd  = lcg_next(imem_rnd);
                imem_wait = imem_rnd[17:16];
            end
            if (imem_wait == 2'd0) begin
                // Very first fetch of the run must start at word 0
                if (first_fetch)
                    check_adr("imem_adr_o", imem_adr, '0);
                first_fetch = 1'b0;
                if ({22'd0, imem_adr} >= prog_words[31:0]) begin
                    $display("Fetch outside the program image at word %h", imem_adr);
                    abort_run();
                end
                imem_dat = imem[imem_adr];
                imem_ack = 1'b1;
            end else begin
                imem_wait = imem_wait - 2'd1;
            end
        end
    end

    // Data memory slave, stores checked in the ack cycle
    always @(negedge clk_i) begin
        if (rst_i || dmem_ack) begin
            dmem_ack  = 1'b0;
            dmem_pend = 1'b0;
        end else if (dmem_cyc && dmem_stb) begin
            if (!dmem_pend) begin
                dmem_pend = 1'b1;
                dmem_rnd  = lcg_next(dmem_rnd);
                dmem_wait = dmem_rnd[17:16];
            end
            if (dmem_wait == 2'd0) begin
                if (dmem_we) begin
                    if (exp_adr_q.size() == 0) begin
                        $display("Store to word %h that no S line expects", dmem_adr);
                        abort_run();
                    end
                    got_adr = exp_adr_q.pop_front();
                    check_adr("dmem_adr_o", dmem_adr, got_adr);
                    check_word("dmem_dat_o", dmem_wdat, exp_dat_q.pop_front());
                    dmem[dmem_adr] = dmem_wdat;
                    store_cnt++;
                end else begin
                    dmem_rdat = dmem[dmem_adr];
                end
                dmem_ack = 1'b1;
            end else begin
                dmem_wait = dmem_wait - 2'd1;
            end
        end
    end

    // Watchdog, scaled by program size
    initial begin
        wait (prog_words > 0);
        repeat (CYCLES_PER_WORD * prog_words) @(posedge clk_i);
        $display("Timeout, the core did not halt in time");
        abort_run();
    end

    initial begin
        rst_i       = 1'b1;
        imem_ack    = 1'b0;
        imem_dat    = '0;
        dmem_ack    = 1'b0;
        dmem_rdat   = '0;
        imem_pend   = 1'b0;
        dmem_pend   = 1'b0;
        imem_wait   = 2'd0;
        dmem_wait   = 2'd0;
        first_fetch = 1'b1;
        imem_rnd    = 32'hf715d1e6;
        dmem_rnd    = lcg_next(32'hf715d1e6);
        // Unloaded words have opcode 0 and so halt the core
        for (int i = 0; i < 2**IADR_WIDTH; i++)
            imem[i] = {i[9:0], 22'd0};
        for (int i = 0; i < 2**DADR_WIDTH; i++)
            dmem[i] = 32'h5a000000 | i;
        load_testdata();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        while (!halt)
            @(negedge clk_i);
        // Halted core stays off both buses
        repeat (HALT_IDLE) begin
            @(negedge clk_i);
            if (imem_cyc || dmem_cyc) begin
                $display("Bus cycle started after halt");
                abort_run();
            end
        end
        if (exp_adr_q.size() != 0) begin
            $display("FAILED store_cnt: got %h, expected %h", store_cnt,
                     store_cnt + exp_adr_q.size());
            abort_run();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end
endmodule

// File: dv/secv_testdata.txt
# P <word address> <instruction>, D <word address> <data>, S <word address> <store data>
# All values hex; S lines in the order the program stores them
P 00 00500093
P 01 FFD00113
P 02 002081B3
P 03 00302023
P 04 40208233
P 05 00402223
P 06 001122B3
P 07 00113333
P 08 00502423
P 09 00602623
P 0A 401153B3
P 0B 00115433
P 0C 001094B3
P 0D 0093C533
P 0E 00802823
P 0F 00A02A23
P 10 123455B7
P 11 6785E593
P 12 00001617
P 13 00B02C23
P 14 00C02E23
P 15 04002683
P 16 0F06F713
P 17 00D70733
P 18 04E02023
P 19 00208463
P 1A 02102023
P 1B 00209463
P 1C 02202223
P 1D 00114463
P 1E 02202223
P 1F 00116463
P 20 02302423
P 21 0020D463
P 22 02202223
P 23 0020F463
P 24 00C007EF
P 25 02F02623
P 26 0100006F
P 27 02302823
P 28 00078867
P 29 02202223
P 2A 00700013
P 2B 02002A23
P 2C 03002C23
P 2D 00000000
D 10 00000123
S 00 00000002
S 01 00000008
S 02 00000001
S 03 00000000
S 04 07FFFFFF
S 05 FFFFFF5F
S 06 12345678
S 07 00001048
S 10 00000143
S 08 00000005
S 0A 00000002
S 0C 00000002
S 0B 00000094
S 0D 00000000
S 0E 000000A4

// File: src.f
hdl/secv_pkg.sv
hdl/secv_decode.sv
hdl/secv_execute.sv
hdl/secv_writeback.sv
hdl/secv_control.sv
hdl/secv_top.sv
dv/secv_bus_asserts.sv
dv/secv_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status reflects the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module secv_tb \
    -Mdir obj_dir -o secv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/secv_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
